//--- Bender.yml
package:
  name: wb_commit

sources:
  - files:
      - verilog/wb_pipe_pkg.sv
      - verilog/csr_pkg.sv
      - verilog/wb_stage.sv
      - verilog/csr_file.sv
      - verilog/reg_file.sv
      - verilog/wb_commit_top.sv
  - target: test
    files:
      - dv/wb_commit_tb.sv

//--- dv/wb_commit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wb_commit_tb;

  import wb_pipe_pkg::*;
  import csr_pkg::*;

  localparam int CYCLE_NS       = 10;
  localparam int RAND_COUNT     = 200;
  localparam int DIRECTED_COUNT = 40;
  localparam int SCAN_COUNT     = 5;
  // Random slots may sit idle, so each one gets four cycles of budget.
  localparam int RUN_CYCLES = 16 + RAND_COUNT * 4 + DIRECTED_COUNT * 2 + SCAN_COUNT * 32;

  logic                  clk;
  logic                  reset;
  logic                  ms2ws_valid;
  logic [XLEN-1:0]       ms2ws_pc;
  logic                  ms2ws_gr_we;
  logic [REG_ADDR_W-1:0] ms2ws_dest;
  logic [XLEN-1:0]       ms2ws_result;
  logic [XLEN-1:0]       ms2ws_rkd_value;
  logic                  ms2ws_csr_re;
  logic                  ms2ws_csr_we;
  logic [CSR_NUM_W-1:0]  ms2ws_csr_num;
  logic [XLEN-1:0]       ms2ws_csr_wmask;
  logic                  ms2ws_ex;
  logic                  ms2ws_ertn;
  logic [ECODE_W-1:0]    ms2ws_ecode;
  logic [ESUBCODE_W-1:0] ms2ws_esubcode;
  logic [XLEN-1:0]       ms2ws_badv;
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic                  ws_allowin;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic                  ws_flush;
  logic [XLEN-1:0]       ws_flush_pc;
  logic [XLEN-1:0]       debug_wb_pc;
  logic [3:0]            debug_wb_rf_we;
  logic [REG_ADDR_W-1:0] debug_wb_rf_wnum;
  logic [XLEN-1:0]       debug_wb_rf_wdata;

  logic [XLEN-1:0] model_regs [NUM_REGS];
  logic [XLEN-1:0] model_csr [int]; // Keyed by CSR number. Unknown numbers are absent.
  logic [XLEN-1:0] pc_next;
  logic [XLEN-1:0] last_pc;
  logic [31:0]     rng_state;
  int errors;
  int checks;
  int tests_run;
  int tests_failed;

  wb_commit_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CYCLE_NS / 2) clk = ~clk;
  end

  initial begin
    #(RUN_CYCLES * CYCLE_NS * 2);
    $display("watchdog expired after %0d ns, the tests did not finish", $time);
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_regnum(input string name, input logic [REG_ADDR_W-1:0] got,
                                input logic [REG_ADDR_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  function automatic logic [XLEN-1:0] writable_bits(input logic [CSR_NUM_W-1:0] num);
    case (num)
      CSR_CRMD:   return CRMD_WMASK;
      CSR_PRMD:   return PRMD_WMASK;
      CSR_ESTAT:  return ESTAT_WMASK;
      CSR_EENTRY: return EENTRY_WMASK;
      CSR_ERA, CSR_BADV, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return '1;
      default:    return '0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] csr_expected(input logic [CSR_NUM_W-1:0] num);
    return model_csr.exists(int'(num)) ? model_csr[int'(num)] : '0;
  endfunction

  task automatic model_csr_write(input logic [CSR_NUM_W-1:0] num, input logic [XLEN-1:0] value,
                                 input logic [XLEN-1:0] wmask);
    logic [XLEN-1:0] bits;
    bits = wmask & writable_bits(num);
    if (bits != '0) begin
      model_csr[int'(num)] = (model_csr[int'(num)] & ~bits) | (value & bits);
    end
  endtask

  task automatic clear_fields();
    ms2ws_gr_we     = 1'b0;
    ms2ws_dest      = '0;
    ms2ws_result    = '0;
    ms2ws_rkd_value = '0;
    ms2ws_csr_re    = 1'b0;
    ms2ws_csr_we    = 1'b0;
    ms2ws_csr_num   = '0;
    ms2ws_csr_wmask = '0;
    ms2ws_ex        = 1'b0;
    ms2ws_ertn      = 1'b0;
    ms2ws_ecode     = '0;
    ms2ws_esubcode  = '0;
    ms2ws_badv      = '0;
  endtask

  task automatic wait_allowin();
    int waited;
    waited = 0;
    while (!ws_allowin && waited < 16) begin
      @(negedge clk);
      waited++;
    end
    if (!ws_allowin) begin
      errors++;
      $display("error at %0t: ws_allowin stayed low, no instruction could be offered", $time);
    end
  endtask

  // Offers the prepared fields for one cycle. On return the instruction sits in the stage.
  task automatic send();
    wait_allowin();
    ms2ws_pc    = pc_next;
    last_pc     = pc_next;
    pc_next     = pc_next + 4;
    ms2ws_valid = 1'b1;
    @(negedge clk);
    ms2ws_valid = 1'b0;
  endtask

  task automatic check_trace(input logic we, input logic [XLEN-1:0] pc,
                             input logic [REG_ADDR_W-1:0] num, input logic [XLEN-1:0] data);
    compare_flag("debug_wb_rf_we", &debug_wb_rf_we, we);
    compare_flag("debug_wb_rf_we", |debug_wb_rf_we, we);
    if (we) begin
      compare_word("debug_wb_pc", debug_wb_pc, pc);
      compare_regnum("debug_wb_rf_wnum", debug_wb_rf_wnum, num);
      compare_word("debug_wb_rf_wdata", debug_wb_rf_wdata, data);
    end
  endtask

  task automatic scan_regs();
    for (int i = 0; i < NUM_REGS; i++) begin
      rs1_addr = i;
      rs2_addr = NUM_REGS - 1 - i;
      #1;
      compare_word($sformatf("rs1_data of r%0d", i), rs1_data, model_regs[i]);
      compare_word($sformatf("rs2_data of r%0d", NUM_REGS - 1 - i), rs2_data,
                   model_regs[NUM_REGS - 1 - i]);
      @(negedge clk);
    end
  endtask

  task automatic retire_write(input logic [REG_ADDR_W-1:0] dest, input logic [XLEN-1:0] data);
    clear_fields();
    ms2ws_gr_we  = 1'b1;
    ms2ws_dest   = dest;
    ms2ws_result = data;
    send();
    check_trace(1'b1, last_pc, dest, data);
    if (dest != '0) model_regs[dest] = data;
    @(negedge clk); // The write lands on the edge before this one.
  endtask

  task automatic csr_op(input logic [CSR_NUM_W-1:0] num, input logic rd, input logic wr,
                        input logic [XLEN-1:0] value, input logic [XLEN-1:0] wmask,
                        input logic [REG_ADDR_W-1:0] dest);
    logic [XLEN-1:0] old;
    old = csr_expected(num);
    clear_fields();
    ms2ws_gr_we     = rd;
    ms2ws_dest      = dest;
    ms2ws_result    = 32'hdead_0000; // Must lose against the CSR value.
    ms2ws_csr_re    = rd;
    ms2ws_csr_we    = wr;
    ms2ws_csr_num   = num;
    ms2ws_csr_wmask = wmask;
    ms2ws_rkd_value = value;
    send();
    check_trace(rd, last_pc, dest, old);
    if (rd && dest != '0) model_regs[dest] = old;
    if (wr) model_csr_write(num, value, wmask);
    @(negedge clk);
  endtask

  task automatic raise_exception(input logic [ECODE_W-1:0] code,
                                 input logic [ESUBCODE_W-1:0] sub, input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] estat;
    clear_fields();
    ms2ws_ex       = 1'b1;
    ms2ws_ecode    = code;
    ms2ws_esubcode = sub;
    ms2ws_badv     = addr;
    ms2ws_gr_we    = 1'b1;
    ms2ws_dest     = 5'd9;
    ms2ws_result   = 32'h0bad_0009;
    send();
    compare_flag("ws_flush", ws_flush, 1'b1);
    compare_word("ws_flush_pc", ws_flush_pc, csr_expected(CSR_EENTRY));
    check_trace(1'b0, '0, '0, '0);
    // A younger instruction offered now belongs to the flushed path.
    ms2ws_ex     = 1'b0;
    ms2ws_dest   = 5'd10;
    ms2ws_result = 32'h0bad_000a;
    ms2ws_valid  = 1'b1;
    estat = model_csr[CSR_ESTAT];
    estat[ESTAT_ECODE_LSB +: ECODE_W]       = code;
    estat[ESTAT_ESUBCODE_LSB +: ESUBCODE_W] = sub;
    model_csr[CSR_ESTAT] = estat;
    model_csr[CSR_PRMD] = (model_csr[CSR_PRMD] & ~32'h7) | (model_csr[CSR_CRMD] & 32'h7);
    model_csr[CSR_CRMD] = model_csr[CSR_CRMD] & ~32'h7;
    model_csr[CSR_ERA]  = last_pc;
    if (code == ECODE_ADEF || code == ECODE_ALE) model_csr[CSR_BADV] = addr;
    @(negedge clk);
    ms2ws_valid = 1'b0;
    compare_flag("ws_flush", ws_flush, 1'b0);
    check_trace(1'b0, '0, '0, '0);
    for (int i = 0; i < 5; i++) begin
      csr_op(i == 0 ? CSR_ERA : i == 1 ? CSR_ESTAT : i == 2 ? CSR_PRMD : i == 3 ? CSR_CRMD
             : CSR_BADV, 1'b1, 1'b0, '0, '0, 5'(20 + i));
    end
  endtask

  task automatic after_reset();
    compare_flag("ws_allowin", ws_allowin, 1'b1);
    compare_flag("ws_flush", ws_flush, 1'b0);
    check_trace(1'b0, '0, '0, '0);
    scan_regs();
    retire_write(5'd0, 32'hdead_beef); // Traced, but r0 stays zero.
    scan_regs();
  endtask

  task automatic plain_writes();
    retire_write(5'd1, 32'h0000_0001);
    retire_write(5'd2, 32'hcafe_f00d);
    retire_write(5'd31, 32'h8000_0000);
    retire_write(5'd2, 32'h1234_abcd);
    retire_write(5'd17, 32'hffff_ffff);
    scan_regs();
  endtask

  task automatic csr_access();
    csr_op(CSR_SAVE0, 1'b1, 1'b1, 32'h1234_5678, '1, 5'd5);
    csr_op(CSR_SAVE0, 1'b1, 1'b1, 32'hffff_0000, 32'h00ff_00ff, 5'd6);
    csr_op(CSR_SAVE0, 1'b1, 1'b0, '0, '0, 5'd7);
    csr_op(CSR_CRMD, 1'b1, 1'b1, '1, 32'h0000_00f5, 5'd8);
    csr_op(CSR_CRMD, 1'b1, 1'b1, 32'hffff_fff7, '1, 5'd9);
    csr_op(CSR_CRMD, 1'b1, 1'b0, '0, '0, 5'd10);
    csr_op(14'h100, 1'b1, 1'b1, '1, '1, 5'd11);
    csr_op(14'h100, 1'b1, 1'b0, '0, '0, 5'd12);
    csr_op(CSR_ESTAT, 1'b0, 1'b1, '1, '1, 5'd0);
    csr_op(CSR_EENTRY, 1'b0, 1'b1, 32'h1c00_80ff, '1, 5'd0);
    csr_op(CSR_EENTRY, 1'b1, 1'b0, '0, '0, 5'd13);
  endtask

  task automatic exception_entry();
    raise_exception(ECODE_SYS, 9'h000, 32'h0bad_0001);
    raise_exception(ECODE_ALE, 9'h001, 32'h1c00_00f3);
    scan_regs();
  endtask

  task automatic exception_return();
    csr_op(CSR_PRMD, 1'b0, 1'b1, 32'h0000_0006, '1, 5'd0);
    clear_fields();
    ms2ws_ertn = 1'b1;
    send();
    compare_flag("ws_flush", ws_flush, 1'b1);
    compare_word("ws_flush_pc", ws_flush_pc, csr_expected(CSR_ERA));
    check_trace(1'b0, '0, '0, '0);
    model_csr[CSR_CRMD] = (model_csr[CSR_CRMD] & ~32'h7) | (model_csr[CSR_PRMD] & 32'h7);
    @(negedge clk);
    compare_flag("ws_flush", ws_flush, 1'b0);
    csr_op(CSR_CRMD, 1'b1, 1'b0, '0, '0, 5'd25);
  endtask

  // Back to back writes with random idle cycles, checked one trace cycle at a time.
  task automatic random_writes();
    logic                  held;
    logic [XLEN-1:0]       held_pc;
    logic [REG_ADDR_W-1:0] held_dest;
    logic [XLEN-1:0]       held_data;
    logic [31:0]           r;
    int                    sent;
    held = 1'b0;
    sent = 0;
    while (sent < RAND_COUNT || held) begin
      if (held) begin
        check_trace(1'b1, held_pc, held_dest, held_data);
        if (held_dest != '0) model_regs[held_dest] = held_data;
      end else begin
        check_trace(1'b0, '0, '0, '0);
      end
      r = next_rand();
      held = (sent < RAND_COUNT) && (r[31:30] != 2'b00);
      if (held) begin
        wait_allowin();
        clear_fields();
        held_pc   = pc_next;
        held_dest = r[20:16];
        held_data = next_rand();
        pc_next   = pc_next + 4;
        ms2ws_pc     = held_pc;
        ms2ws_gr_we  = 1'b1;
        ms2ws_dest   = held_dest;
        ms2ws_result = held_data;
        sent++;
      end
      ms2ws_valid = held;
      @(negedge clk);
    end
    scan_regs();
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%-18s ok", name);
    end else begin
      tests_failed++;
      $display("%-18s %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    int mark;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rng_state    = 32'd45149;
    pc_next      = 32'h1c00_0000;
    last_pc      = '0;
    reset        = 1'b1;
    ms2ws_valid  = 1'b0;
    ms2ws_pc     = '0;
    rs1_addr     = '0;
    rs2_addr     = '0;
    clear_fields();
    foreach (model_regs[i]) model_regs[i] = '0;
    model_csr[CSR_CRMD]   = CRMD_RESET;
    model_csr[CSR_PRMD]   = '0;
    model_csr[CSR_ESTAT]  = '0;
    model_csr[CSR_ERA]    = '0;
    model_csr[CSR_BADV]   = '0;
    model_csr[CSR_EENTRY] = '0;
    for (int i = 0; i < 4; i++) model_csr[int'(CSR_SAVE0) + i] = '0;
    repeat (16) @(negedge clk);
    reset = 1'b0;

    mark = errors;
    after_reset();
    report_test("after_reset", mark);
    mark = errors;
    plain_writes();
    report_test("plain_writes", mark);
    mark = errors;
    csr_access();
    report_test("csr_access", mark);
    mark = errors;
    exception_entry();
    report_test("exception_entry", mark);
    mark = errors;
    exception_return();
    report_test("exception_return", mark);
    mark = errors;
    random_writes();
    report_test("random_writes", mark);

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               csr_we,
  input  logic [wb_pipe_pkg::CSR_NUM_W-1:0]  csr_num,
  input  logic [wb_pipe_pkg::XLEN-1:0]       csr_wmask,
  input  logic [wb_pipe_pkg::XLEN-1:0]       csr_wvalue,
  input  logic                               ex,
  input  logic                               ertn,
  input  logic [wb_pipe_pkg::ECODE_W-1:0]    ecode,
  input  logic [wb_pipe_pkg::ESUBCODE_W-1:0] esubcode,
  input  logic [wb_pipe_pkg::XLEN-1:0]       badv,
  input  logic [wb_pipe_pkg::XLEN-1:0]       pc,
  output logic [wb_pipe_pkg::XLEN-1:0]       csr_rvalue,
  output logic [wb_pipe_pkg::XLEN-1:0]       flush_target
);

  import wb_pipe_pkg::*;
  import csr_pkg::*;

  logic [XLEN-1:0] csr_crmd;
  logic [XLEN-1:0] csr_prmd;
  logic [XLEN-1:0] csr_estat;
  logic [XLEN-1:0] csr_era;
  logic [XLEN-1:0] csr_badv;
  logic [XLEN-1:0] csr_eentry;
  logic [XLEN-1:0] csr_save [4];

  logic       wr_any;
  logic       wr_crmd;
  logic       wr_prmd;
  logic       wr_estat;
  logic       wr_era;
  logic       wr_badv;
  logic       wr_eentry;
  logic       wr_save;
  logic [1:0] save_idx;
  logic       badv_hit;

  // Old bits survive outside the write mask and outside the writable field.
  function automatic logic [XLEN-1:0] masked_merge(
    input logic [XLEN-1:0] old_value,
    input logic [XLEN-1:0] writable
  );
    logic [XLEN-1:0] bits;
    bits = csr_wmask & writable;
    return (old_value & ~bits) | (csr_wvalue & bits);
  endfunction

  // An exception or ertn in the same instruction wins over a CSR write.
  assign wr_any    = csr_we && !ex && !ertn;
  assign wr_crmd   = wr_any && (csr_num == CSR_CRMD);
  assign wr_prmd   = wr_any && (csr_num == CSR_PRMD);
  assign wr_estat  = wr_any && (csr_num == CSR_ESTAT);
  assign wr_era    = wr_any && (csr_num == CSR_ERA);
  assign wr_badv   = wr_any && (csr_num == CSR_BADV);
  assign wr_eentry = wr_any && (csr_num == CSR_EENTRY);
  assign wr_save   = wr_any && (csr_num[CSR_NUM_W-1:2] == CSR_SAVE0[CSR_NUM_W-1:2]);
  assign save_idx  = csr_num[1:0];

  assign badv_hit = (ecode == ECODE_ADEF) || (ecode == ECODE_ALE);

  always_ff @(posedge clk) begin
    if (reset) begin
      csr_crmd <= CRMD_RESET;
    end else if (ex) begin
      csr_crmd[PLV_IE_MSB:0] <= '0; // Enter kernel level with interrupts masked.
    end else if (ertn) begin
      csr_crmd[PLV_IE_MSB:0] <= csr_prmd[PLV_IE_MSB:0];
    end else if (wr_crmd) begin
      csr_crmd <= masked_merge(csr_crmd, CRMD_WMASK);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      csr_prmd <= '0;
    end else if (ex) begin
      csr_prmd[PLV_IE_MSB:0] <= csr_crmd[PLV_IE_MSB:0];
    end else if (wr_prmd) begin
      csr_prmd <= masked_merge(csr_prmd, PRMD_WMASK);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      csr_estat <= '0;
    end else if (ex) begin
      csr_estat[ESTAT_ECODE_LSB +: ECODE_W]       <= ecode;
      csr_estat[ESTAT_ESUBCODE_LSB +: ESUBCODE_W] <= esubcode;
    end else if (wr_estat) begin
      csr_estat <= masked_merge(csr_estat, ESTAT_WMASK);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      csr_era  <= '0;
      csr_badv <= '0;
    end else begin
      if (ex) begin
        csr_era <= pc;
      end else if (wr_era) begin
        csr_era <= masked_merge(csr_era, '1);
      end
      if (ex && badv_hit) begin
        csr_badv <= badv; // Only address faults report a bad address.
      end else if (wr_badv) begin
        csr_badv <= masked_merge(csr_badv, '1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      csr_eentry <= '0;
      for (int i = 0; i < 4; i++) begin
        csr_save[i] <= '0;
      end
    end else begin
      if (wr_eentry) begin
        csr_eentry <= masked_merge(csr_eentry, EENTRY_WMASK);
      end
      if (wr_save) begin
        csr_save[save_idx] <= masked_merge(csr_save[save_idx], '1);
      end
    end
  end

  // The read value is the state before this instruction's own write.
  always_comb begin
    case (csr_num)
      CSR_CRMD:   csr_rvalue = csr_crmd;
      CSR_PRMD:   csr_rvalue = csr_prmd;
      CSR_ESTAT:  csr_rvalue = csr_estat;
      CSR_ERA:    csr_rvalue = csr_era;
      CSR_BADV:   csr_rvalue = csr_badv;
      CSR_EENTRY: csr_rvalue = csr_eentry;
      CSR_SAVE0:  csr_rvalue = csr_save[0];
      CSR_SAVE1:  csr_rvalue = csr_save[1];
      CSR_SAVE2:  csr_rvalue = csr_save[2];
      CSR_SAVE3:  csr_rvalue = csr_save[3];
      default:    csr_rvalue = '0;
    endcase
  end

  assign flush_target = ex ? csr_eentry : csr_era;

endmodule

`default_nettype wire

//--- verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

  import wb_pipe_pkg::*;

  // CSR numbers of the exception handling subset.
  localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h000;
  localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h001;
  localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h005;
  localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h006;
  localparam logic [CSR_NUM_W-1:0] CSR_BADV   = 14'h007;
  localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'h00c;
  localparam logic [CSR_NUM_W-1:0] CSR_SAVE0  = 14'h030; // SAVE0 to SAVE3 share one aligned block.
  localparam logic [CSR_NUM_W-1:0] CSR_SAVE1  = 14'h031;
  localparam logic [CSR_NUM_W-1:0] CSR_SAVE2  = 14'h032;
  localparam logic [CSR_NUM_W-1:0] CSR_SAVE3  = 14'h033;

  // Exception codes.
  localparam logic [ECODE_W-1:0] ECODE_ADEF = 6'h08; // Fetch address error.
  localparam logic [ECODE_W-1:0] ECODE_ALE  = 6'h09; // Misaligned load or store.
  localparam logic [ECODE_W-1:0] ECODE_SYS  = 6'h0b;
  localparam logic [ECODE_W-1:0] ECODE_INE  = 6'h0d;

  // Bits that software may change through csrwr and csrxchg.
  localparam logic [XLEN-1:0] CRMD_WMASK   = 32'h0000_0007; // PLV and IE.
  localparam logic [XLEN-1:0] PRMD_WMASK   = 32'h0000_0007; // PPLV and PIE.
  localparam logic [XLEN-1:0] ESTAT_WMASK  = 32'h0000_0003; // Software interrupts.
  localparam logic [XLEN-1:0] EENTRY_WMASK = 32'hffff_ffc0;

  // Direct address translation on, kernel level, interrupts off.
  localparam logic [XLEN-1:0] CRMD_RESET = 32'h0000_0008;

  // PLV and IE sit in bits 2:0 of CRMD, and PPLV and PIE in the same bits of PRMD.
  localparam int unsigned PLV_IE_MSB = 2;

  // Field positions inside ESTAT.
  localparam int unsigned ESTAT_ECODE_LSB    = 16;
  localparam int unsigned ESTAT_ESUBCODE_LSB = 22;

endpackage

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               we,
  input  logic [wb_pipe_pkg::REG_ADDR_W-1:0] waddr,
  input  logic [wb_pipe_pkg::XLEN-1:0]       wdata,
  input  logic [wb_pipe_pkg::REG_ADDR_W-1:0] raddr1,
  input  logic [wb_pipe_pkg::REG_ADDR_W-1:0] raddr2,
  output logic [wb_pipe_pkg::XLEN-1:0]       rdata1,
  output logic [wb_pipe_pkg::XLEN-1:0]       rdata2
);

  import wb_pipe_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // No bypass. A read in the write cycle still sees the old value.
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- verilog/wb_commit_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_commit_top (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               ms2ws_valid,
  input  logic [wb_pipe_pkg::XLEN-1:0]       ms2ws_pc,
  input  logic                               ms2ws_gr_we,
  input  logic [wb_pipe_pkg::REG_ADDR_W-1:0] ms2ws_dest,
  input  logic [wb_pipe_pkg::XLEN-1:0]       ms2ws_result,
  input  logic [wb_pipe_pkg::XLEN-1:0]       ms2ws_rkd_value,
  input  logic                               ms2ws_csr_re,
  input  logic                               ms2ws_csr_we,
  input  logic [wb_pipe_pkg::CSR_NUM_W-1:0]  ms2ws_csr_num,
  input  logic [wb_pipe_pkg::XLEN-1:0]       ms2ws_csr_wmask,
  input  logic                               ms2ws_ex,
  input  logic                               ms2ws_ertn,
  input  logic [wb_pipe_pkg::ECODE_W-1:0]    ms2ws_ecode,
  input  logic [wb_pipe_pkg::ESUBCODE_W-1:0] ms2ws_esubcode,
  input  logic [wb_pipe_pkg::XLEN-1:0]       ms2ws_badv,
  input  logic [wb_pipe_pkg::REG_ADDR_W-1:0] rs1_addr,
  input  logic [wb_pipe_pkg::REG_ADDR_W-1:0] rs2_addr,
  output logic                               ws_allowin,
  output logic [wb_pipe_pkg::XLEN-1:0]       rs1_data,
  output logic [wb_pipe_pkg::XLEN-1:0]       rs2_data,
  output logic                               ws_flush,
  output logic [wb_pipe_pkg::XLEN-1:0]       ws_flush_pc,
  output logic [wb_pipe_pkg::XLEN-1:0]       debug_wb_pc,
  output logic [3:0]                         debug_wb_rf_we,
  output logic [wb_pipe_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum,
  output logic [wb_pipe_pkg::XLEN-1:0]       debug_wb_rf_wdata
);

  import wb_pipe_pkg::*;

  // Retiring instruction as seen by the CSR file.
  logic                  csr_we;
  logic [CSR_NUM_W-1:0]  csr_num;
  logic [XLEN-1:0]       csr_wmask;
  logic [XLEN-1:0]       csr_wvalue;
  logic                  ex;
  logic                  ertn;
  logic [ECODE_W-1:0]    ecode;
  logic [ESUBCODE_W-1:0] esubcode;
  logic [XLEN-1:0]       badv;
  logic [XLEN-1:0]       pc;
  logic [XLEN-1:0]       csr_rvalue;
  logic [XLEN-1:0]       flush_target;

  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;

  wb_stage u_wb_stage (.*);

  csr_file u_csr_file (
    .clk          (clk),
    .reset        (reset),
    .csr_we       (csr_we),
    .csr_num      (csr_num),
    .csr_wmask    (csr_wmask),
    .csr_wvalue   (csr_wvalue),
    .ex           (ex),
    .ertn         (ertn),
    .ecode        (ecode),
    .esubcode     (esubcode),
    .badv         (badv),
    .pc           (pc),
    .csr_rvalue   (csr_rvalue),
    .flush_target (flush_target)
  );

  reg_file u_reg_file (
    .clk    (clk),
    .reset  (reset),
    .we     (rf_we),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata),
    .raddr1 (rs1_addr),
    .raddr2 (rs2_addr),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

endmodule

`default_nettype wire

//--- verilog/wb_pipe_pkg.sv
`default_nettype none

package wb_pipe_pkg;

  // Data path and program counter width.
  localparam int unsigned XLEN = 32;

  // General register file geometry.
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  // CSR number as carried in the csrrd, csrwr and csrxchg encodings.
  localparam int unsigned CSR_NUM_W = 14;

  // Exception code and subcode widths, as stored in ESTAT.
  localparam int unsigned ECODE_W    = 6;
  localparam int unsigned ESUBCODE_W = 9;

endpackage

`default_nettype wire

//--- verilog/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               ms2ws_valid,
  input  logic [wb_pipe_pkg::XLEN-1:0]       ms2ws_pc,
  input  logic                               ms2ws_gr_we,
  input  logic [wb_pipe_pkg::REG_ADDR_W-1:0] ms2ws_dest,
  input  logic [wb_pipe_pkg::XLEN-1:0]       ms2ws_result,
  input  logic [wb_pipe_pkg::XLEN-1:0]       ms2ws_rkd_value,
  input  logic                               ms2ws_csr_re,
  input  logic                               ms2ws_csr_we,
  input  logic [wb_pipe_pkg::CSR_NUM_W-1:0]  ms2ws_csr_num,
  input  logic [wb_pipe_pkg::XLEN-1:0]       ms2ws_csr_wmask,
  input  logic                               ms2ws_ex,
  input  logic                               ms2ws_ertn,
  input  logic [wb_pipe_pkg::ECODE_W-1:0]    ms2ws_ecode,
  input  logic [wb_pipe_pkg::ESUBCODE_W-1:0] ms2ws_esubcode,
  input  logic [wb_pipe_pkg::XLEN-1:0]       ms2ws_badv,
  input  logic [wb_pipe_pkg::XLEN-1:0]       csr_rvalue,
  input  logic [wb_pipe_pkg::XLEN-1:0]       flush_target,
  output logic                               ws_allowin,
  output logic                               csr_we,
  output logic [wb_pipe_pkg::CSR_NUM_W-1:0]  csr_num,
  output logic [wb_pipe_pkg::XLEN-1:0]       csr_wmask,
  output logic [wb_pipe_pkg::XLEN-1:0]       csr_wvalue,
  output logic                               ex,
  output logic                               ertn,
  output logic [wb_pipe_pkg::ECODE_W-1:0]    ecode,
  output logic [wb_pipe_pkg::ESUBCODE_W-1:0] esubcode,
  output logic [wb_pipe_pkg::XLEN-1:0]       badv,
  output logic [wb_pipe_pkg::XLEN-1:0]       pc,
  output logic                               rf_we,
  output logic [wb_pipe_pkg::REG_ADDR_W-1:0] rf_waddr,
  output logic [wb_pipe_pkg::XLEN-1:0]       rf_wdata,
  output logic                               ws_flush,
  output logic [wb_pipe_pkg::XLEN-1:0]       ws_flush_pc,
  output logic [wb_pipe_pkg::XLEN-1:0]       debug_wb_pc,
  output logic [3:0]                         debug_wb_rf_we,
  output logic [wb_pipe_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum,
  output logic [wb_pipe_pkg::XLEN-1:0]       debug_wb_rf_wdata
);

  import wb_pipe_pkg::*;

  logic                  ws_valid;
  logic                  ws_ready_go;
  logic [XLEN-1:0]       ws_pc;
  logic                  ws_gr_we;
  logic [REG_ADDR_W-1:0] ws_dest;
  logic [XLEN-1:0]       ws_result;
  logic [XLEN-1:0]       ws_rkd_value;
  logic                  ws_csr_re;
  logic                  ws_csr_we;
  logic [CSR_NUM_W-1:0]  ws_csr_num;
  logic [XLEN-1:0]       ws_csr_wmask;
  logic                  ws_ex;
  logic                  ws_ertn;
  logic [ECODE_W-1:0]    ws_ecode;
  logic [ESUBCODE_W-1:0] ws_esubcode;
  logic [XLEN-1:0]       ws_badv;

  assign ws_ready_go = 1'b1; // Retirement never stalls.
  assign ws_allowin  = !ws_valid || ws_ready_go;

  // A flush empties the stage and drops whatever is offered on the same edge.
  always_ff @(posedge clk) begin
    if (reset) begin
      ws_valid <= 1'b0;
    end else if (ws_flush) begin
      ws_valid <= 1'b0;
    end else if (ws_allowin) begin
      ws_valid <= ms2ws_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ms2ws_valid && ws_allowin) begin
      ws_pc        <= ms2ws_pc;
      ws_gr_we     <= ms2ws_gr_we;
      ws_dest      <= ms2ws_dest;
      ws_result    <= ms2ws_result;
      ws_rkd_value <= ms2ws_rkd_value;
      ws_csr_re    <= ms2ws_csr_re;
      ws_csr_we    <= ms2ws_csr_we;
      ws_csr_num   <= ms2ws_csr_num;
      ws_csr_wmask <= ms2ws_csr_wmask;
      ws_ex        <= ms2ws_ex;
      ws_ertn      <= ms2ws_ertn;
      ws_ecode     <= ms2ws_ecode;
      ws_esubcode  <= ms2ws_esubcode;
      ws_badv      <= ms2ws_badv;
    end
  end

  // Only the controls with side effects need the valid qualifier.
  assign csr_we     = ws_valid && ws_csr_we;
  assign ex         = ws_valid && ws_ex;
  assign ertn       = ws_valid && ws_ertn;
  assign csr_num    = ws_csr_num;
  assign csr_wmask  = ws_csr_wmask;
  assign csr_wvalue = ws_rkd_value; // csrwr and csrxchg write the rd operand.
  assign ecode      = ws_ecode;
  assign esubcode   = ws_esubcode;
  assign badv       = ws_badv;
  assign pc         = ws_pc;

  assign rf_we    = ws_valid && ws_gr_we && !ws_ex;
  assign rf_waddr = ws_dest;
  assign rf_wdata = ws_csr_re ? csr_rvalue : ws_result;

  assign ws_flush    = ex || ertn;
  assign ws_flush_pc = flush_target;

  assign debug_wb_pc       = ws_pc;
  assign debug_wb_rf_we    = {4{rf_we}};
  assign debug_wb_rf_wnum  = rf_waddr;
  assign debug_wb_rf_wdata = rf_wdata;

endmodule

`default_nettype wire

//--- wb_commit_top.f
verilog/wb_pipe_pkg.sv
verilog/csr_pkg.sv
verilog/wb_stage.sv
verilog/csr_file.sv
verilog/reg_file.sv
verilog/wb_commit_top.sv
dv/wb_commit_tb.sv
